//--- common/rv_isa_pkg.sv
// RV32I encodings and word types
`default_nettype none

package rv_isa_pkg;

	// architectural vector types
	typedef logic [31:0] word_t;
	typedef logic [31:0] instr_t;
	typedef logic [4:0]  reg_addr_t;

	// major opcodes, instr[6:0]
	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_JAL    = 7'b1101111;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_LOAD   = 7'b0000011;
	localparam logic [6:0] OPC_STORE  = 7'b0100011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_OP     = 7'b0110011;

	// funct3 for register and immediate ALU ops
	// SUB shares 000 with ADD, told apart by instr[30]
	localparam logic [2:0] F3_ADD_SUB = 3'b000;
	localparam logic [2:0] F3_SLT     = 3'b010;
	localparam logic [2:0] F3_SLTU    = 3'b011;
	localparam logic [2:0] F3_XOR     = 3'b100;
	localparam logic [2:0] F3_OR      = 3'b110;
	localparam logic [2:0] F3_AND     = 3'b111;

	// funct3 for conditional branches
	// bit 0 inverts the base compare
	localparam logic [2:0] F3_BEQ     = 3'b000;
	localparam logic [2:0] F3_BNE     = 3'b001;
	localparam logic [2:0] F3_BLT     = 3'b100;
	localparam logic [2:0] F3_BGE     = 3'b101;
	localparam logic [2:0] F3_BLTU    = 3'b110;
	localparam logic [2:0] F3_BGEU    = 3'b111;

endpackage

`default_nettype wire

//--- common/core_pkg.sv
// Core control enums
`default_nettype none

package core_pkg;

	// main sequencer states
	typedef enum logic [2:0] {
		FETCH,
		DECODE,
		EXECUTE,
		MEM_READ,
		MEM_WRITE
	} core_state_e;

	// ALU functions left after the cut to word-only RV32I
	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		ALU_SLTU
	} alu_op_e;

	// first ALU operand
	typedef enum logic {
		OPA_REG,
		OPA_PC
	} operand_a_e;

	// second ALU operand
	typedef enum logic {
		OPB_REG,
		OPB_IMM
	} operand_b_e;

	// source of the rd write data
	typedef enum logic [1:0] {
		WB_ALU,
		WB_LINK,
		WB_LOAD
	} wb_src_e;

endpackage

`default_nettype wire

//--- verilog/instr_decode.sv
// Instruction register and decoder
`timescale 1ns/1ps
`default_nettype none

module instr_decode (
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  fetch_accept,
	input  rv_isa_pkg::instr_t    idata,
	output rv_isa_pkg::reg_addr_t rs1,
	output rv_isa_pkg::reg_addr_t rs2,
	output rv_isa_pkg::reg_addr_t rd,
	output logic [2:0]            funct3,
	output rv_isa_pkg::word_t     imm,
	output core_pkg::alu_op_e     alu_op,
	output core_pkg::operand_a_e  opa_sel,
	output core_pkg::operand_b_e  opb_sel,
	output core_pkg::wb_src_e     wb_src,
	output logic                  is_load,
	output logic                  is_store,
	output logic                  is_branch,
	output logic                  is_jal,
	output logic                  writes_rd
);

	rv_isa_pkg::instr_t instr;
	logic [6:0]         opcode;
	logic               is_lui;
	logic               is_alu;
	logic               f3_known;
	core_pkg::alu_op_e  f3_op;

	// captured on the fetch handshake, held for the rest of the instruction
	always_ff @(posedge clock) begin
		if (reset) begin
			instr <= '0;
		end else if (fetch_accept) begin
			instr <= idata;
		end
	end

	assign opcode = instr[6:0];
	assign funct3 = instr[14:12];

	assign is_lui    = (opcode == rv_isa_pkg::OPC_LUI);
	assign is_jal    = (opcode == rv_isa_pkg::OPC_JAL);
	assign is_branch = (opcode == rv_isa_pkg::OPC_BRANCH);
	assign is_load   = (opcode == rv_isa_pkg::OPC_LOAD);
	assign is_store  = (opcode == rv_isa_pkg::OPC_STORE);
	assign is_alu    = (opcode == rv_isa_pkg::OPC_OP_IMM) || (opcode == rv_isa_pkg::OPC_OP);

	// LUI reads x0 so that rs1 + imm gives the upper immediate
	assign rs1 = is_lui ? 5'd0 : instr[19:15];
	assign rs2 = instr[24:20];
	assign rd  = instr[11:7];

	// shift codes 001/101 fall out here and retire as no-ops
	always_comb begin
		f3_known = 1'b1;
		case (funct3)
			rv_isa_pkg::F3_ADD_SUB: begin
				// bit 30 only means SUB for register ops
				if ((opcode == rv_isa_pkg::OPC_OP) && instr[30]) begin
					f3_op = core_pkg::ALU_SUB;
				end else begin
					f3_op = core_pkg::ALU_ADD;
				end
			end
			rv_isa_pkg::F3_SLT:  f3_op = core_pkg::ALU_SLT;
			rv_isa_pkg::F3_SLTU: f3_op = core_pkg::ALU_SLTU;
			rv_isa_pkg::F3_XOR:  f3_op = core_pkg::ALU_XOR;
			rv_isa_pkg::F3_OR:   f3_op = core_pkg::ALU_OR;
			rv_isa_pkg::F3_AND:  f3_op = core_pkg::ALU_AND;
			default: begin
				f3_op    = core_pkg::ALU_ADD;
				f3_known = 1'b0;
			end
		endcase
	end

	// address and target math all use ADD
	assign alu_op    = is_alu ? f3_op : core_pkg::ALU_ADD;
	assign opa_sel   = (is_jal || is_branch) ? core_pkg::OPA_PC : core_pkg::OPA_REG;
	assign opb_sel   = (opcode == rv_isa_pkg::OPC_OP) ? core_pkg::OPB_REG : core_pkg::OPB_IMM;
	assign wb_src    = is_jal ? core_pkg::WB_LINK :
		is_load ? core_pkg::WB_LOAD : core_pkg::WB_ALU;
	assign writes_rd = is_lui || is_jal || is_load || (is_alu && f3_known);

	// sign-extended immediate per format
	always_comb begin
		if (is_lui) begin
			imm = {instr[31:12], 12'd0};
		end else if (is_jal) begin
			imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
		end else if (is_branch) begin
			imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
		end else if (is_store) begin
			imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
		end else begin
			imm = {{20{instr[31]}}, instr[31:20]};
		end
	end

endmodule

`default_nettype wire

//--- verilog/register_file.sv
// Integer register file
`timescale 1ns/1ps
`default_nettype none

module register_file (
	input  logic                  clock,
	input  logic                  reset,
	input  rv_isa_pkg::reg_addr_t ra_addr,
	input  rv_isa_pkg::reg_addr_t rb_addr,
	input  rv_isa_pkg::reg_addr_t rd_addr,
	input  rv_isa_pkg::word_t     rd_wdata,
	input  logic                  rd_wen,
	output rv_isa_pkg::word_t     ra_data,
	output rv_isa_pkg::word_t     rb_data
);

	rv_isa_pkg::word_t regs [0:31];

	// x0 never takes a write
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (rd_wen && (rd_addr != 5'd0)) begin
			regs[rd_addr] <= rd_wdata;
		end
	end

	// async read, x0 forced to zero
	assign ra_data = (ra_addr == 5'd0) ? '0 : regs[ra_addr];
	assign rb_data = (rb_addr == 5'd0) ? '0 : regs[rb_addr];

endmodule

`default_nettype wire

//--- core/execute_unit.sv
// Operand select, ALU and branch compare
`timescale 1ns/1ps
`default_nettype none

module execute_unit (
	input  rv_isa_pkg::word_t    rs1_data,
	input  rv_isa_pkg::word_t    rs2_data,
	input  rv_isa_pkg::word_t    imm,
	input  rv_isa_pkg::word_t    pc,
	input  rv_isa_pkg::word_t    drdata,
	input  core_pkg::alu_op_e    alu_op,
	input  core_pkg::operand_a_e opa_sel,
	input  core_pkg::operand_b_e opb_sel,
	input  core_pkg::wb_src_e    wb_src,
	input  logic                 is_branch,
	input  logic [2:0]           funct3,
	output rv_isa_pkg::word_t    alu_out,
	output rv_isa_pkg::word_t    rd_wdata,
	output rv_isa_pkg::word_t    daddr,
	output rv_isa_pkg::word_t    dwdata,
	output rv_isa_pkg::word_t    target,
	output logic                 branch_taken
);

	rv_isa_pkg::word_t op_a;
	rv_isa_pkg::word_t op_b;
	logic              cmp_eq;
	logic              cmp_lt;
	logic              cmp_ltu;

	// pc feeds JAL and branch targets
	assign op_a = (opa_sel == core_pkg::OPA_PC) ? pc : rs1_data;
	assign op_b = (opb_sel == core_pkg::OPB_IMM) ? imm : rs2_data;

	always_comb begin
		case (alu_op)
			core_pkg::ALU_ADD:  alu_out = op_a + op_b;
			core_pkg::ALU_SUB:  alu_out = op_a - op_b;
			core_pkg::ALU_AND:  alu_out = op_a & op_b;
			core_pkg::ALU_OR:   alu_out = op_a | op_b;
			core_pkg::ALU_XOR:  alu_out = op_a ^ op_b;
			core_pkg::ALU_SLT:  alu_out = {31'd0, $signed(op_a) < $signed(op_b)};
			core_pkg::ALU_SLTU: alu_out = {31'd0, op_a < op_b};
			default:            alu_out = op_a + op_b;
		endcase
	end

	// branch compare always on the two registers, never the immediate
	assign cmp_eq  = (rs1_data == rs2_data);
	assign cmp_lt  = ($signed(rs1_data) < $signed(rs2_data));
	assign cmp_ltu = (rs1_data < rs2_data);

	always_comb begin
		case (funct3)
			rv_isa_pkg::F3_BEQ:  branch_taken = is_branch && cmp_eq;
			rv_isa_pkg::F3_BNE:  branch_taken = is_branch && !cmp_eq;
			rv_isa_pkg::F3_BLT:  branch_taken = is_branch && cmp_lt;
			rv_isa_pkg::F3_BGE:  branch_taken = is_branch && !cmp_lt;
			rv_isa_pkg::F3_BLTU: branch_taken = is_branch && cmp_ltu;
			rv_isa_pkg::F3_BGEU: branch_taken = is_branch && !cmp_ltu;
			// 010 and 011 are not branch codes
			default:             branch_taken = 1'b0;
		endcase
	end

	// write-back mux
	always_comb begin
		case (wb_src)
			core_pkg::WB_LINK: rd_wdata = pc + 32'd4;
			core_pkg::WB_LOAD: rd_wdata = drdata;
			default:           rd_wdata = alu_out;
		endcase
	end

	// word accesses only, low address bits dropped
	assign daddr  = {alu_out[31:2], 2'b00};
	assign dwdata = rs2_data;
	assign target = alu_out;

endmodule

`default_nettype wire

//--- core/core_control.sv
// Core sequencer and program counter
`timescale 1ns/1ps
`default_nettype none

module core_control #(
	parameter rv_isa_pkg::word_t RESET_VECTOR = 32'h0000_0000
) (
	input  logic              clock,
	input  logic              reset,
	input  logic              iready,
	input  logic              dready,
	input  logic              is_load,
	input  logic              is_store,
	input  logic              is_branch,
	input  logic              is_jal,
	input  logic              writes_rd,
	input  logic              branch_taken,
	input  rv_isa_pkg::word_t target,
	output rv_isa_pkg::word_t iaddr,
	output rv_isa_pkg::word_t pc,
	output logic              ivalid,
	output logic              fetch_accept,
	output logic              dvalid,
	output logic              dwrite,
	output logic              rd_wen
);

	core_pkg::core_state_e state;
	rv_isa_pkg::word_t     pc_next;

	// bus requests follow the state directly
	assign ivalid       = (state == core_pkg::FETCH);
	assign fetch_accept = ivalid && iready;
	assign dvalid       = (state == core_pkg::MEM_READ) || (state == core_pkg::MEM_WRITE);
	assign dwrite       = (state == core_pkg::MEM_WRITE);

	// pc stays put until the instruction retires, so iaddr is stable under a stall
	assign iaddr = pc;

	// taken jump or branch, else fall through
	assign pc_next = (is_jal || (is_branch && branch_taken)) ? target : pc + 32'd4;

	// loads write back on the data handshake, everything else in EXECUTE
	always_comb begin
		rd_wen = 1'b0;
		if (state == core_pkg::EXECUTE) begin
			rd_wen = writes_rd && !is_load;
		end else if (state == core_pkg::MEM_READ) begin
			rd_wen = writes_rd && dready;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= core_pkg::FETCH;
			pc    <= RESET_VECTOR;
		end else begin
			case (state)
				core_pkg::FETCH: begin
					if (fetch_accept) begin
						state <= core_pkg::DECODE;
					end
				end
				// decode is registered, one cycle to settle
				core_pkg::DECODE: begin
					state <= core_pkg::EXECUTE;
				end
				core_pkg::EXECUTE: begin
					if (is_load) begin
						state <= core_pkg::MEM_READ;
					end else if (is_store) begin
						state <= core_pkg::MEM_WRITE;
					end else begin
						pc    <= pc_next;
						state <= core_pkg::FETCH;
					end
				end
				// hold the access until the memory answers
				core_pkg::MEM_READ, core_pkg::MEM_WRITE: begin
					if (dready) begin
						pc    <= pc_next;
						state <= core_pkg::FETCH;
					end
				end
				default: begin
					state <= core_pkg::FETCH;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- core/core_top.sv
// Multi-cycle RV32I core
`timescale 1ns/1ps
`default_nettype none

module core_top #(
	parameter rv_isa_pkg::word_t RESET_VECTOR = 32'h0000_0000
) (
	input  logic               clock,
	input  logic               reset,
	output rv_isa_pkg::word_t  iaddr,
	input  rv_isa_pkg::instr_t idata,
	output logic               ivalid,
	input  logic               iready,
	output rv_isa_pkg::word_t  daddr,
	output rv_isa_pkg::word_t  dwdata,
	input  rv_isa_pkg::word_t  drdata,
	output logic               dwrite,
	output logic               dvalid,
	input  logic               dready
);

	// control <-> datapath
	rv_isa_pkg::word_t      pc;
	rv_isa_pkg::word_t      target;
	logic                   fetch_accept;
	logic                   branch_taken;
	logic                   rd_wen;

	// decode outputs
	logic                   is_load;
	logic                   is_store;
	logic                   is_branch;
	logic                   is_jal;
	logic                   writes_rd;
	logic [2:0]             funct3;
	rv_isa_pkg::reg_addr_t  rs1;
	rv_isa_pkg::reg_addr_t  rs2;
	rv_isa_pkg::reg_addr_t  rd;
	rv_isa_pkg::word_t      imm;
	core_pkg::alu_op_e      alu_op;
	core_pkg::operand_a_e   opa_sel;
	core_pkg::operand_b_e   opb_sel;
	core_pkg::wb_src_e      wb_src;

	// register file ports
	rv_isa_pkg::word_t      rs1_data;
	rv_isa_pkg::word_t      rs2_data;
	rv_isa_pkg::word_t      rd_wdata;

	core_control #(
		.RESET_VECTOR (RESET_VECTOR)
	) control_i (
		.clock        (clock),
		.reset        (reset),
		.iready       (iready),
		.dready       (dready),
		.is_load      (is_load),
		.is_store     (is_store),
		.is_branch    (is_branch),
		.is_jal       (is_jal),
		.writes_rd    (writes_rd),
		.branch_taken (branch_taken),
		.target       (target),
		.iaddr        (iaddr),
		.pc           (pc),
		.ivalid       (ivalid),
		.fetch_accept (fetch_accept),
		.dvalid       (dvalid),
		.dwrite       (dwrite),
		.rd_wen       (rd_wen)
	);

	instr_decode decode_i (
		.clock        (clock),
		.reset        (reset),
		.fetch_accept (fetch_accept),
		.idata        (idata),
		.rs1          (rs1),
		.rs2          (rs2),
		.rd           (rd),
		.funct3       (funct3),
		.imm          (imm),
		.alu_op       (alu_op),
		.opa_sel      (opa_sel),
		.opb_sel      (opb_sel),
		.wb_src       (wb_src),
		.is_load      (is_load),
		.is_store     (is_store),
		.is_branch    (is_branch),
		.is_jal       (is_jal),
		.writes_rd    (writes_rd)
	);

	register_file regfile_i (
		.clock    (clock),
		.reset    (reset),
		.ra_addr  (rs1),
		.rb_addr  (rs2),
		.rd_addr  (rd),
		.rd_wdata (rd_wdata),
		.rd_wen   (rd_wen),
		.ra_data  (rs1_data),
		.rb_data  (rs2_data)
	);

	// raw alu result already reaches the buses as daddr and target
	execute_unit execute_i (
		.rs1_data     (rs1_data),
		.rs2_data     (rs2_data),
		.imm          (imm),
		.pc           (pc),
		.drdata       (drdata),
		.alu_op       (alu_op),
		.opa_sel      (opa_sel),
		.opb_sel      (opb_sel),
		.wb_src       (wb_src),
		.is_branch    (is_branch),
		.funct3       (funct3),
		.alu_out      (),
		.rd_wdata     (rd_wdata),
		.daddr        (daddr),
		.dwdata       (dwdata),
		.target       (target),
		.branch_taken (branch_taken)
	);

endmodule

`default_nettype wire

//--- test/tb_clock_gen.sv
// Testbench clock and reset
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
	parameter int HALF_PERIOD  = 2,
	parameter int RESET_CYCLES = 8
) (
	input  logic restart,
	output logic clock,
	output logic reset
);

	logic clock_q = 1'b0;
	logic reset_q = 1'b1;
	int   count   = 0;

	always #(HALF_PERIOD) clock_q = ~clock_q;

	// reset held over RESET_CYCLES rising edges, again after a restart pulse
	always @(posedge clock_q) begin
		if (restart) begin
			reset_q <= 1'b1;
			count   <= 0;
		end else if (reset_q) begin
			count <= count + 1;
			if (count == RESET_CYCLES - 1) begin
				reset_q <= 1'b0;
			end
		end
	end

	assign clock = clock_q;
	assign reset = reset_q;

endmodule

`default_nettype wire

//--- test/tb_top.sv
// Core testbench
`timescale 1ns/1ps
`default_nettype none

module tb_top;

	localparam rv_isa_pkg::word_t RESET_VECTOR  = 32'h0000_0100;
	localparam rv_isa_pkg::word_t DATA_BASE     = 32'h0000_1000;
	localparam int                STORE_TIMEOUT = 2000;

	logic               clock;
	logic               reset;
	logic               restart    = 1'b0;
	logic               stall_mode = 1'b0;
	int                 seed       = 59679;

	// DUT ports
	rv_isa_pkg::word_t  iaddr;
	rv_isa_pkg::instr_t idata  = '0;
	logic               ivalid;
	logic               iready = 1'b0;
	rv_isa_pkg::word_t  daddr;
	rv_isa_pkg::word_t  dwdata;
	rv_isa_pkg::word_t  drdata = '0;
	logic               dwrite;
	logic               dvalid;
	logic               dready = 1'b0;

	// program and expected store tables
	rv_isa_pkg::instr_t prog [$];
	rv_isa_pkg::word_t  exp_addr [$];
	rv_isa_pkg::word_t  exp_data [$];

	// memory models and observed stores
	rv_isa_pkg::instr_t imem [rv_isa_pkg::word_t];
	rv_isa_pkg::word_t  dmem [rv_isa_pkg::word_t];
	rv_isa_pkg::word_t  store_addr [$];
	rv_isa_pkg::word_t  store_data [$];

	// previous-edge request state for the hold checks
	logic               i_wait = 1'b0;
	logic               d_wait = 1'b0;
	rv_isa_pkg::word_t  i_addr_q = '0;
	rv_isa_pkg::word_t  d_addr_q = '0;
	rv_isa_pkg::word_t  d_wdata_q = '0;

	tb_clock_gen #(
		.HALF_PERIOD  (2),
		.RESET_CYCLES (8)
	) clock_gen_i (
		.restart (restart),
		.clock   (clock),
		.reset   (reset)
	);

	core_top #(
		.RESET_VECTOR (RESET_VECTOR)
	) dut_i (
		.clock  (clock),
		.reset  (reset),
		.iaddr  (iaddr),
		.idata  (idata),
		.ivalid (ivalid),
		.iready (iready),
		.daddr  (daddr),
		.dwdata (dwdata),
		.drdata (drdata),
		.dwrite (dwrite),
		.dvalid (dvalid),
		.dready (dready)
	);

	task automatic fail_now(input string msg);
		$display("%s", msg);
		$display("Test FAILED");
		$fatal(1);
	endtask

	task automatic check_word(input string what, input rv_isa_pkg::word_t got,
			input rv_isa_pkg::word_t exp);
		if (got !== exp) begin
			fail_now($sformatf("mismatch at %0t ns: %s is %h, expected %h", $time, what, got, exp));
		end
	endtask

	task automatic check_flag(input string what, input logic got, input logic exp);
		if (got !== exp) begin
			fail_now($sformatf("mismatch at %0t ns: %s is %b, expected %b", $time, what, got, exp));
		end
	endtask

	// RV32I instruction encoders
	function automatic rv_isa_pkg::instr_t r_type(logic [6:0] f7, int rs2, int rs1,
			logic [2:0] f3, int rd);
		return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], 7'b0110011};
	endfunction

	function automatic rv_isa_pkg::instr_t i_type(int imm, int rs1, logic [2:0] f3, int rd,
			logic [6:0] opc);
		return {imm[11:0], rs1[4:0], f3, rd[4:0], opc};
	endfunction

	function automatic rv_isa_pkg::instr_t s_type(int imm, int rs2, int rs1);
		return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
	endfunction

	function automatic rv_isa_pkg::instr_t b_type(logic [2:0] f3, int rs1, int rs2, int off);
		return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3, off[4:1], off[11], 7'b1100011};
	endfunction

	function automatic rv_isa_pkg::instr_t j_type(int rd, int off);
		return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'b1101111};
	endfunction

	function automatic rv_isa_pkg::instr_t u_type(int rd, int imm);
		return {imm[19:0], rd[4:0], 7'b0110111};
	endfunction

	// SW relative to x10, with the word it must write
	task automatic add_store(input int rs2, input int off, input rv_isa_pkg::word_t data);
		prog.push_back(s_type(off, rs2, 10));
		exp_addr.push_back(DATA_BASE + off);
		exp_data.push_back(data);
	endtask

	// skipped store to 0x107c, never expected
	task automatic taken_branch(input logic [2:0] f3, input int rs1, input int rs2);
		prog.push_back(b_type(f3, rs1, rs2, 8));
		prog.push_back(s_type('h07c, 2, 10));
	endtask

	// not taken counts up x20
	task automatic fallthrough_branch(input logic [2:0] f3, input int rs1, input int rs2);
		prog.push_back(b_type(f3, rs1, rs2, 8));
		prog.push_back(i_type(1, 20, 0, 20, 7'b0010011));
	endtask

	task automatic build_program();
		rv_isa_pkg::word_t link;
		// x1 upper imm, x2 = 100, x3 = -7, x10 data base
		prog.push_back(u_type(1, 'h12345));
		prog.push_back(i_type(100, 0, 0, 2, 7'b0010011));
		prog.push_back(i_type(-7, 0, 0, 3, 7'b0010011));
		prog.push_back(u_type(10, 1));
		add_store(1, 0, 32'h1234_5000);
		// register forms
		prog.push_back(r_type(7'h00, 3, 2, 3'b000, 4));
		add_store(4, 4, 32'd93);
		prog.push_back(r_type(7'h20, 3, 2, 3'b000, 5));
		add_store(5, 8, 32'd107);
		prog.push_back(r_type(7'h00, 3, 2, 3'b111, 6));
		add_store(6, 12, 32'h0000_0060);
		prog.push_back(r_type(7'h00, 3, 2, 3'b110, 7));
		add_store(7, 16, 32'hffff_fffd);
		prog.push_back(r_type(7'h00, 3, 2, 3'b100, 8));
		add_store(8, 20, 32'hffff_ff9d);
		prog.push_back(r_type(7'h00, 2, 3, 3'b010, 9));
		add_store(9, 24, 32'd1);
		prog.push_back(r_type(7'h00, 2, 3, 3'b011, 11));
		add_store(11, 28, 32'd0);
		// immediate forms
		prog.push_back(i_type('h0f0, 3, 3'b111, 12, 7'b0010011));
		add_store(12, 32, 32'h0000_00f0);
		prog.push_back(i_type('h700, 2, 3'b110, 13, 7'b0010011));
		add_store(13, 36, 32'h0000_0764);
		prog.push_back(i_type(-1, 2, 3'b100, 14, 7'b0010011));
		add_store(14, 40, 32'hffff_ff9b);
		prog.push_back(i_type(-8, 3, 3'b010, 15, 7'b0010011));
		add_store(15, 44, 32'd0);
		prog.push_back(i_type(-1, 2, 3'b011, 16, 7'b0010011));
		add_store(16, 48, 32'd1);
		prog.push_back(i_type(-100, 3, 3'b000, 22, 7'b0010011));
		add_store(22, 52, 32'hffff_ff95);
		// two preloaded words summed
		prog.push_back(i_type('h100, 10, 3'b010, 17, 7'b0000011));
		prog.push_back(i_type('h104, 10, 3'b010, 18, 7'b0000011));
		prog.push_back(r_type(7'h00, 18, 17, 3'b000, 19));
		add_store(19, 56, 32'hbbbb_0003);
		// every branch once each way
		taken_branch(3'b000, 2, 2);
		fallthrough_branch(3'b000, 2, 3);
		taken_branch(3'b001, 2, 3);
		fallthrough_branch(3'b001, 2, 2);
		taken_branch(3'b100, 3, 2);
		fallthrough_branch(3'b100, 2, 3);
		taken_branch(3'b101, 2, 3);
		fallthrough_branch(3'b101, 3, 2);
		taken_branch(3'b110, 2, 3);
		fallthrough_branch(3'b110, 3, 2);
		taken_branch(3'b111, 3, 2);
		fallthrough_branch(3'b111, 2, 3);
		add_store(20, 60, 32'd6);
		// JAL over a store, link is its own pc plus four
		link = RESET_VECTOR + 4 * prog.size() + 4;
		prog.push_back(j_type(21, 8));
		prog.push_back(s_type('h07c, 2, 10));
		add_store(21, 64, link);
		// park
		prog.push_back(j_type(0, 0));
	endtask

	task automatic hold_until_reset_done();
		int cycles;
		cycles = 0;
		@(negedge clock);
		while (reset) begin
			@(negedge clock);
			cycles++;
			if (cycles > 50) begin
				fail_now("reset was never released by the clock generator");
			end
		end
	endtask

	task automatic await_store();
		int cycles;
		cycles = 0;
		while (store_addr.size() == 0) begin
			@(negedge clock);
			cycles++;
			if (cycles > STORE_TIMEOUT) begin
				fail_now("timeout while waiting for the next data store");
			end
		end
	endtask

	// memory models, one cycle from request to ready
	always @(posedge clock) begin
		if (reset) begin
			iready <= 1'b0;
			dready <= 1'b0;
			i_wait <= 1'b0;
			d_wait <= 1'b0;
		end else begin
			// a stalled request keeps its address
			if (i_wait) begin
				check_word("held iaddr", iaddr, i_addr_q);
			end
			if (d_wait) begin
				check_word("held daddr", daddr, d_addr_q);
				check_word("held dwdata", dwdata, d_wdata_q);
			end
			i_wait    <= ivalid && !iready;
			d_wait    <= dvalid && !dready;
			i_addr_q  <= iaddr;
			d_addr_q  <= daddr;
			d_wdata_q <= dwdata;

			if (ivalid && iready) begin
				iready <= 1'b0;
			end else if (ivalid) begin
				iready <= !stall_mode || (($random(seed) & 1) != 0);
				idata  <= imem[iaddr];
			end

			if (dvalid && dready) begin
				dready <= 1'b0;
				if (dwrite) begin
					dmem[daddr] = dwdata;
					store_addr.push_back(daddr);
					store_data.push_back(dwdata);
				end
			end else if (dvalid) begin
				dready <= !stall_mode || (($random(seed) & 1) != 0);
				drdata <= dmem[daddr];
			end
		end
	end

	initial begin
		rv_isa_pkg::word_t got_addr;
		rv_isa_pkg::word_t got_data;
		build_program();
		foreach (prog[i]) begin
			imem[RESET_VECTOR + 4 * i] = prog[i];
		end
		dmem[DATA_BASE + 32'h100] = 32'haaaa_0001;
		dmem[DATA_BASE + 32'h104] = 32'h1111_0002;

		// second pass reruns under random stalls
		for (int run = 0; run < 2; run++) begin
			if (run == 1) begin
				@(posedge clock);
				stall_mode <= 1'b1;
				restart    <= 1'b1;
				@(posedge clock);
				restart    <= 1'b0;
			end
			hold_until_reset_done();
			store_addr.delete();
			store_data.delete();
			check_flag("ivalid after reset", ivalid, 1'b1);
			check_word("iaddr after reset", iaddr, RESET_VECTOR);
			check_flag("dvalid after reset", dvalid, 1'b0);
			check_flag("dwrite after reset", dwrite, 1'b0);

			for (int i = 0; i < exp_addr.size(); i++) begin
				await_store();
				got_addr = store_addr.pop_front();
				got_data = store_data.pop_front();
				check_word($sformatf("store %0d address", i), got_addr, exp_addr[i]);
				check_word($sformatf("store %0d data", i), got_data, exp_data[i]);
			end
		end

		$display("Test OK");
		$finish;
	end

endmodule

`default_nettype wire

//--- files.f
common/rv_isa_pkg.sv
common/core_pkg.sv
verilog/instr_decode.sv
verilog/register_file.sv
core/execute_unit.sv
core/core_control.sv
core/core_top.sv
test/tb_clock_gen.sv
test/tb_top.sv

//--- run_sim.sh
#!/bin/sh
# build the core testbench with Verilator, run it, judge from sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --top-module tb_top -f files.f -o tb_sim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1
cat sim.log
grep -q "Test FAILED" sim.log && exit 1
grep -q "Test OK" sim.log || exit 1
exit 0
